//--- Bender.yml
package:
  name: csr_file

sources:
  - include_dirs:
      - include
    files:
      - src/csr_pkg.sv
      - src/csr_trap_unit.sv
      - src/csr_pmp_unit.sv
      - src/csr_access_decode.sv
      - src/csr_file.sv
  - target: simulation
    files:
      - tb/csr_ref_model.sv
      - tb/csr_file_tb.sv

//--- files.f
+incdir+include
src/csr_pkg.sv
src/csr_trap_unit.sv
src/csr_pmp_unit.sv
src/csr_access_decode.sv
src/csr_file.sv
tb/csr_ref_model.sv
tb/csr_file_tb.sv

//--- include/csr_map.svh
//////////////////////////////
// machine CSR addresses and field bit positions
// included once by the register file package
//////////////////////////////
`ifndef CSR_MAP_SVH
`define CSR_MAP_SVH

// machine information registers
localparam logic [11:0] MVENDORID    = 12'hF11;
localparam logic [11:0] MARCHID      = 12'hF12;
localparam logic [11:0] MIMPID       = 12'hF13;
localparam logic [11:0] MHARTID      = 12'hF14;

// machine trap setup and handling
localparam logic [11:0] MSTATUS      = 12'h300;
localparam logic [11:0] MISA         = 12'h301;
localparam logic [11:0] MIE          = 12'h304;
localparam logic [11:0] MTVEC        = 12'h305;
localparam logic [11:0] MEPC         = 12'h341;
localparam logic [11:0] MCAUSE       = 12'h342;
localparam logic [11:0] MIP          = 12'h344;

// memory protection, low nibble is the index
localparam logic [11:0] PMPCFG_BASE  = 12'h3A0;
localparam logic [11:0] PMPADDR_BASE = 12'h3B0;

// interrupt enable bits, mip uses the same positions
localparam int MIE_MSIE = 3;
localparam int MIE_MTIE = 7;
localparam int MIE_MEIE = 11;

localparam int MSTATUS_MIE     = 3;
localparam int MSTATUS_MPIE    = 7;
localparam int MSTATUS_MPP_LSB = 11;
localparam int MSTATUS_MPP_MSB = 12;

`endif

//--- src/csr_access_decode.sv
//////////////////////////////
// CSR access decode, legality check and read mux
// purely combinational, answers in the cycle of the request
//////////////////////////////
module csr_access_decode import csr_pkg::*; #(
    parameter int unsigned PMP_ENTRIES = MAX_PMP_ENTRIES
) (
    input  csr_req_t                         csr_req,
    input  privilege_e                       privilege_mode,
    input  logic [XLEN-1:0]                  hartid,
    input  trap_regs_t                       trap_regs,
    input  logic [PMP_ENTRIES-1:0][7:0]      pmpcfg,
    input  logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpaddr,
    output csr_wr_t                          csr_wr,
    output logic [XLEN-1:0]                  csr_rdata,
    output logic                             illegal_csr
);

    logic [3:0]      idx;
    logic            known;
    logic            grant;
    logic [XLEN-1:0] rdata;
    csr_target_e     target;

    assign idx = csr_req.addr[3:0];

    //////////////////////////////
    // address map
    //////////////////////////////
    always_comb begin
        known  = 1'b1;
        rdata  = '0;
        target = TGT_NONE;
        case (csr_req.addr)
            // id registers read zero
            MVENDORID, MARCHID, MIMPID: rdata = '0;
            MHARTID: rdata = hartid;
            MISA:    rdata = ISA_CODE;
            MSTATUS: begin
                rdata  = trap_regs.mstatus;
                target = TGT_MSTATUS;
            end
            MIE: begin
                rdata  = trap_regs.mie;
                target = TGT_MIE;
            end
            MTVEC: begin
                rdata  = trap_regs.mtvec;
                target = TGT_MTVEC;
            end
            MEPC: begin
                rdata  = trap_regs.mepc;
                target = TGT_MEPC;
            end
            MCAUSE: begin
                rdata  = trap_regs.mcause;
                target = TGT_MCAUSE;
            end
            // mip follows the lines, writes are dropped
            MIP: rdata = trap_regs.mip;
            default: begin
                if (csr_req.addr[11:4] == PMPCFG_BASE[11:4] && idx < PMP_ENTRIES / 4) begin
                    rdata  = pmpcfg[4*idx +: 4];
                    target = TGT_PMPCFG;
                end else if (csr_req.addr[11:4] == PMPADDR_BASE[11:4]
                             && idx < PMP_ENTRIES) begin
                    rdata  = pmpaddr[idx];
                    target = TGT_PMPADDR;
                end else begin
                    known = 1'b0;
                end
            end
        endcase
    end

    // only machine mode reaches these registers
    assign grant       = known && (privilege_mode == PRIV_M);
    assign illegal_csr = csr_req.en && !grant;
    assign csr_rdata   = (csr_req.en && grant) ? rdata : '0;

    assign csr_wr = '{
        target: (csr_req.en && grant && csr_req.op != CSR_OP_NONE) ? target : TGT_NONE,
        op:     csr_req.op,
        index:  idx,
        wdata:  csr_req.wdata
    };

endmodule

//--- src/csr_file.sv
//////////////////////////////
// machine-mode CSR file of the RV32 core
// single-cycle CSR access, trap entry and mret, PMP registers
//////////////////////////////
module csr_file import csr_pkg::*; #(
    parameter int unsigned PMP_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  csr_req_t                         csr_req,
    input  trap_req_t                        trap_req,
    input  logic [XLEN-1:0]                  pc_if,
    input  logic [XLEN-1:0]                  pc_wb,
    input  logic [XLEN-1:0]                  hartid,
    input  logic                             extern_intr,
    input  logic                             timer_intr,
    input  logic                             software_intr,
    output logic [XLEN-1:0]                  csr_rdata,
    output logic                             illegal_csr,
    output privilege_e                       privilege_mode,
    output logic                             mstatus_mie,
    output logic [XLEN-1:0]                  mie,
    output logic [XLEN-1:0]                  mtvec,
    output logic [XLEN-1:0]                  mepc,
    output logic [PMP_ENTRIES-1:0][7:0]      pmpcfg,
    output logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpaddr
);

    csr_wr_t    csr_wr;
    trap_regs_t trap_regs;

    csr_access_decode #(
        .PMP_ENTRIES(PMP_ENTRIES)
    ) csr_access_decode_inst (
        .csr_req        (csr_req),
        .privilege_mode (privilege_mode),
        .hartid         (hartid),
        .trap_regs      (trap_regs),
        .pmpcfg         (pmpcfg),
        .pmpaddr        (pmpaddr),
        .csr_wr         (csr_wr),
        .csr_rdata      (csr_rdata),
        .illegal_csr    (illegal_csr)
    );

    csr_trap_unit csr_trap_unit_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .csr_wr         (csr_wr),
        .trap_req       (trap_req),
        .pc_if          (pc_if),
        .pc_wb          (pc_wb),
        .extern_intr    (extern_intr),
        .timer_intr     (timer_intr),
        .software_intr  (software_intr),
        .privilege_mode (privilege_mode),
        .mstatus_mie    (mstatus_mie),
        .trap_regs      (trap_regs),
        .mie            (mie),
        .mtvec          (mtvec),
        .mepc           (mepc)
    );

    csr_pmp_unit #(
        .PMP_ENTRIES(PMP_ENTRIES)
    ) csr_pmp_unit_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .csr_wr  (csr_wr),
        .pmpcfg  (pmpcfg),
        .pmpaddr (pmpaddr)
    );

endmodule

//--- src/csr_pkg.sv
//////////////////////////////
// types and constants shared by the machine CSR file
// import with csr_pkg::* in the module header
//////////////////////////////
package csr_pkg;

    `include "csr_map.svh"

    localparam int XLEN = 32;
    localparam int MAX_PMP_ENTRIES = 16;
    // MXL = 1, I and M extensions
    localparam logic [XLEN-1:0] ISA_CODE = 32'h4000_1100;

    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } privilege_e;

    typedef enum logic [1:0] {
        PMP_OFF,
        PMP_TOR,
        PMP_NA4,
        PMP_NAPOT
    } pmp_mode_e;

    typedef enum logic {
        EPC_PC_IF,
        EPC_PC_WB
    } epc_sel_e;

    typedef enum logic [3:0] {
        TGT_NONE,
        TGT_MSTATUS,
        TGT_MIE,
        TGT_MTVEC,
        TGT_MEPC,
        TGT_MCAUSE,
        TGT_PMPCFG,
        TGT_PMPADDR
    } csr_target_e;

    typedef struct packed {
        logic            en;
        csr_op_e         op;
        logic [11:0]     addr;
        logic [XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        csr_target_e     target;
        csr_op_e         op;
        logic [3:0]      index;
        logic [XLEN-1:0] wdata;
    } csr_wr_t;

    typedef struct packed {
        logic       take;
        logic       mret;
        logic       irq;
        logic [4:0] code;
        epc_sel_e   epc_sel;
    } trap_req_t;

    // architectural layout, only mie, mpie and mpp are implemented
    typedef struct packed {
        logic [18:0] wpri_31_13;
        logic [1:0]  mpp;
        logic [2:0]  wpri_10_8;
        logic        mpie;
        logic [2:0]  wpri_6_4;
        logic        mie;
        logic [2:0]  wpri_2_0;
    } mstatus_t;

    typedef struct packed {
        mstatus_t        mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
    } trap_regs_t;

    // write, set or clear, touching only the bits in mask
    function automatic logic [XLEN-1:0] csr_apply(
        input csr_op_e         op,
        input logic [XLEN-1:0] old_val,
        input logic [XLEN-1:0] wdata,
        input logic [XLEN-1:0] mask
    );
        logic [XLEN-1:0] new_val;
        case (op)
            CSR_OP_WRITE: new_val = wdata;
            CSR_OP_SET:   new_val = old_val | wdata;
            CSR_OP_CLEAR: new_val = old_val & ~wdata;
            default:      new_val = old_val;
        endcase
        return (old_val & ~mask) | (new_val & mask);
    endfunction

endpackage

//--- src/csr_pmp_unit.sv
//////////////////////////////
// PMP configuration and address registers
// locked entries hold until reset
//////////////////////////////
module csr_pmp_unit import csr_pkg::*; #(
    parameter int unsigned PMP_ENTRIES = MAX_PMP_ENTRIES
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  csr_wr_t                          csr_wr,
    output logic [PMP_ENTRIES-1:0][7:0]      pmpcfg,
    output logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpaddr
);

    // four entries per pmpcfg word
    localparam int unsigned CFG_WORDS = PMP_ENTRIES / 4;

    logic [PMP_ENTRIES-1:0][7:0]      cfg_q;
    logic [PMP_ENTRIES-1:0][XLEN-1:0] addr_q;
    logic [CFG_WORDS-1:0][XLEN-1:0]   cfg_word_next;
    logic [PMP_ENTRIES-1:0]           addr_lock;

    if (PMP_ENTRIES == 0 || PMP_ENTRIES % 4 != 0 || PMP_ENTRIES > MAX_PMP_ENTRIES)
    begin : g_bad_entries
        $error("PMP_ENTRIES must be 4, 8, 12 or 16");
    end

    // op applied to the whole packed word, entries then pick their byte
    for (genvar k = 0; k < CFG_WORDS; k++) begin : g_cfg_word
        assign cfg_word_next[k] = csr_apply(csr_wr.op, cfg_q[4*k +: 4], csr_wr.wdata, '1);
    end

    //////////////////////////////
    // per entry
    //////////////////////////////
    for (genvar n = 0; n < PMP_ENTRIES; n++) begin : g_entry
        logic cfg_hit;
        logic addr_hit;

        assign cfg_hit  = (csr_wr.target == TGT_PMPCFG) && (csr_wr.index == 4'(n / 4));
        assign addr_hit = (csr_wr.target == TGT_PMPADDR) && (csr_wr.index == 4'(n));

        // a locked tor entry above also freezes this address
        if (n == PMP_ENTRIES - 1) begin : g_top
            assign addr_lock[n] = cfg_q[n][7];
        end else begin : g_below
            assign addr_lock[n] = cfg_q[n][7]
                || (cfg_q[n+1][7] && pmp_mode_e'(cfg_q[n+1][4:3]) == PMP_TOR);
        end

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                cfg_q[n] <= '0;
            end else if (cfg_hit && !cfg_q[n][7]) begin
                cfg_q[n] <= cfg_word_next[n/4][8*(n%4) +: 8];
            end
        end

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                addr_q[n] <= '0;
            end else if (addr_hit && !addr_lock[n]) begin
                addr_q[n] <= csr_apply(csr_wr.op, addr_q[n], csr_wr.wdata, '1);
            end
        end

        // only reset can release a lock
        a_lock_holds: assert property (@(posedge clk) disable iff (!reset_n)
            cfg_q[n][7] |=> $stable(cfg_q[n]));
    end

    assign pmpcfg  = cfg_q;
    assign pmpaddr = addr_q;

endmodule

//--- src/csr_trap_unit.sv
//////////////////////////////
// trap registers and privilege mode
// CSR writes come in decoded, trap and mret from the core
//////////////////////////////
module csr_trap_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  csr_wr_t         csr_wr,
    input  trap_req_t       trap_req,
    input  logic [XLEN-1:0] pc_if,
    input  logic [XLEN-1:0] pc_wb,
    input  logic            extern_intr,
    input  logic            timer_intr,
    input  logic            software_intr,
    output privilege_e      privilege_mode,
    output logic            mstatus_mie,
    output trap_regs_t      trap_regs,
    output logic [XLEN-1:0] mie,
    output logic [XLEN-1:0] mtvec,
    output logic [XLEN-1:0] mepc
);

    // writable bits per register
    localparam logic [XLEN-1:0] MSTATUS_WMASK = (XLEN'(1) << MSTATUS_MIE)
                                              | (XLEN'(1) << MSTATUS_MPIE)
                                              | (XLEN'(3) << MSTATUS_MPP_LSB);
    localparam logic [XLEN-1:0] MIE_WMASK     = (XLEN'(1) << MIE_MSIE)
                                              | (XLEN'(1) << MIE_MTIE)
                                              | (XLEN'(1) << MIE_MEIE);
    localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFF_FF03;
    localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFE;
    localparam logic [XLEN-1:0] MCAUSE_WMASK  = 32'h8000_001F;

    mstatus_t        mstatus_q;
    mstatus_t        mstatus_n;
    privilege_e      priv_q;
    privilege_e      priv_n;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mie_n;
    logic [XLEN-1:0] mip_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mtvec_n;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mepc_n;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mcause_n;
    logic [XLEN-1:0] trap_pc;

    assign trap_pc = (trap_req.epc_sel == EPC_PC_WB) ? pc_wb : pc_if;

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        mstatus_n = mstatus_q;
        mepc_n    = mepc_q;
        mcause_n  = mcause_q;
        priv_n    = priv_q;

        // trap wins over mret
        if (trap_req.take) begin
            mstatus_n.mie  = 1'b0;
            mstatus_n.mpie = mstatus_q.mie;
            mstatus_n.mpp  = priv_q;
            mepc_n         = {trap_pc[XLEN-1:1], 1'b0};
            mcause_n       = {trap_req.irq, {(XLEN-6){1'b0}}, trap_req.code};
            priv_n         = PRIV_M;
        end else if (trap_req.mret) begin
            mstatus_n.mie  = mstatus_q.mpie;
            mstatus_n.mpie = 1'b1;
            mstatus_n.mpp  = PRIV_U;
            priv_n         = privilege_e'(mstatus_q.mpp);
        end

        // a CSR instruction overrides the trap update of the same register
        case (csr_wr.target)
            TGT_MSTATUS: mstatus_n = csr_apply(csr_wr.op, mstatus_q, csr_wr.wdata,
                                               MSTATUS_WMASK);
            TGT_MEPC:    mepc_n    = csr_apply(csr_wr.op, mepc_q, csr_wr.wdata, MEPC_WMASK);
            TGT_MCAUSE:  mcause_n  = csr_apply(csr_wr.op, mcause_q, csr_wr.wdata,
                                               MCAUSE_WMASK);
            default: ;
        endcase
    end

    assign mie_n   = (csr_wr.target == TGT_MIE)
                   ? csr_apply(csr_wr.op, mie_q, csr_wr.wdata, MIE_WMASK) : mie_q;
    assign mtvec_n = (csr_wr.target == TGT_MTVEC)
                   ? csr_apply(csr_wr.op, mtvec_q, csr_wr.wdata, MTVEC_WMASK) : mtvec_q;

    //////////////////////////////
    // registers
    //////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_q      <= '0;
            mstatus_q.mpie <= 1'b1;
            mstatus_q.mpp  <= PRIV_U;
            priv_q         <= PRIV_M;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
        end else begin
            mstatus_q <= mstatus_n;
            priv_q    <= priv_n;
            mie_q     <= mie_n;
            mtvec_q   <= mtvec_n;
            mepc_q    <= mepc_n;
            mcause_q  <= mcause_n;
        end
    end

    // pending bits sit at the same positions as the enables
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q <= '0;
        end else begin
            mip_q           <= '0;
            mip_q[MIE_MEIE] <= extern_intr;
            mip_q[MIE_MTIE] <= timer_intr;
            mip_q[MIE_MSIE] <= software_intr;
        end
    end

    assign privilege_mode = priv_q;
    assign mstatus_mie    = mstatus_q.mie;
    assign mie            = mie_q;
    assign mtvec          = mtvec_q;
    assign mepc           = mepc_q;

    assign trap_regs = '{
        mstatus: mstatus_q,
        mie:     mie_q,
        mip:     mip_q,
        mtvec:   mtvec_q,
        mepc:    mepc_q,
        mcause:  mcause_q
    };

    // the core never asks for trap entry and return together
    a_take_mret_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(trap_req.take && trap_req.mret));

endmodule

//--- tb/csr_file_tb.sv
//////////////////////////////
// testbench for the machine CSR file
// random CSR accesses, traps and interrupts against the reference model
//////////////////////////////
module csr_file_tb import csr_pkg::*; ();

    localparam int unsigned PMP_ENTRIES    = 16;
    localparam int unsigned RESET_CYCLES   = 8;
    localparam int unsigned NUM_RANDOM     = 3000;
    // reset, directed reads and random cycles fit well below this
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                             clk;
    logic                             reset_n;
    csr_req_t                         csr_req;
    trap_req_t                        trap_req;
    logic [XLEN-1:0]                  pc_if;
    logic [XLEN-1:0]                  pc_wb;
    logic [XLEN-1:0]                  hartid;
    logic                             extern_intr;
    logic                             timer_intr;
    logic                             software_intr;
    logic [XLEN-1:0]                  csr_rdata;
    logic                             illegal_csr;
    privilege_e                       privilege_mode;
    logic                             mstatus_mie;
    logic [XLEN-1:0]                  mie;
    logic [XLEN-1:0]                  mtvec;
    logic [XLEN-1:0]                  mepc;
    logic [PMP_ENTRIES-1:0][7:0]      pmpcfg;
    logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpaddr;
    logic [XLEN-1:0]                  exp_rdata;
    logic                             exp_illegal;
    logic [1:0]                       exp_priv;
    logic                             exp_mstatus_mie;
    logic [XLEN-1:0]                  exp_mie;
    logic [XLEN-1:0]                  exp_mtvec;
    logic [XLEN-1:0]                  exp_mepc;
    logic [PMP_ENTRIES-1:0][7:0]      exp_pmpcfg;
    logic [PMP_ENTRIES-1:0][XLEN-1:0] exp_pmpaddr;
    logic [11:0]                      csr_addrs[$];
    int unsigned                      cycle_count = 0;

    csr_file #(
        .PMP_ENTRIES(PMP_ENTRIES)
    ) csr_file_inst (
        .clk(clk), .reset_n(reset_n), .csr_req(csr_req), .trap_req(trap_req),
        .pc_if(pc_if), .pc_wb(pc_wb), .hartid(hartid), .extern_intr(extern_intr),
        .timer_intr(timer_intr), .software_intr(software_intr), .csr_rdata(csr_rdata),
        .illegal_csr(illegal_csr), .privilege_mode(privilege_mode),
        .mstatus_mie(mstatus_mie), .mie(mie), .mtvec(mtvec), .mepc(mepc),
        .pmpcfg(pmpcfg), .pmpaddr(pmpaddr)
    );

    csr_ref_model #(
        .PMP_ENTRIES(PMP_ENTRIES)
    ) ref_model (
        .clk(clk), .reset_n(reset_n), .csr_req(csr_req), .trap_req(trap_req),
        .pc_if(pc_if), .pc_wb(pc_wb), .hartid(hartid), .extern_intr(extern_intr),
        .timer_intr(timer_intr), .software_intr(software_intr), .exp_rdata(exp_rdata),
        .exp_illegal(exp_illegal), .exp_priv(exp_priv), .exp_mstatus_mie(exp_mstatus_mie),
        .exp_mie(exp_mie), .exp_mtvec(exp_mtvec), .exp_mepc(exp_mepc),
        .exp_pmpcfg(exp_pmpcfg), .exp_pmpaddr(exp_pmpaddr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("the run did not finish within the cycle limit");
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure("output mismatch against the reference model");
        end
    endtask

    task automatic compare_outputs();
        check_value("csr_rdata", csr_rdata, exp_rdata);
        check_value("illegal_csr", 32'(illegal_csr), 32'(exp_illegal));
        check_value("privilege_mode", 32'(privilege_mode), 32'(exp_priv));
        check_value("mstatus_mie", 32'(mstatus_mie), 32'(exp_mstatus_mie));
        check_value("mie", mie, exp_mie);
        check_value("mtvec", mtvec, exp_mtvec);
        check_value("mepc", mepc, exp_mepc);
        for (int n = 0; n < PMP_ENTRIES; n++) begin
            check_value($sformatf("pmpcfg[%0d]", n), 32'(pmpcfg[n]), 32'(exp_pmpcfg[n]));
            check_value($sformatf("pmpaddr[%0d]", n), pmpaddr[n], exp_pmpaddr[n]);
        end
    endtask

    // mostly implemented addresses, with unimplemented ones mixed in
    task automatic drive_random_cycle();
        logic [11:0] addr;
        addr = ($urandom_range(0, 99) < 85) ? csr_addrs[$urandom_range(0, csr_addrs.size() - 1)]
                                            : 12'($urandom);
        csr_req.en    = $urandom_range(0, 9) != 0;
        csr_req.op    = csr_op_e'($urandom_range(0, 3));
        csr_req.addr  = addr;
        csr_req.wdata = $urandom;
        // keep most pmpcfg writes unlocked so entries stay writable for a while
        if (addr[11:4] == PMPCFG_BASE[11:4] && $urandom_range(0, 7) != 0) begin
            csr_req.wdata = csr_req.wdata & 32'h7F7F_7F7F;
        end
        trap_req.take    = $urandom_range(0, 23) == 0;
        trap_req.mret    = !trap_req.take && $urandom_range(0, 15) == 0;
        trap_req.irq     = $urandom_range(0, 1);
        trap_req.code    = 5'($urandom);
        trap_req.epc_sel = epc_sel_e'($urandom_range(0, 1));
        pc_if            = $urandom;
        pc_wb            = $urandom;
        extern_intr      = $urandom_range(0, 1);
        timer_intr       = $urandom_range(0, 1);
        software_intr    = $urandom_range(0, 1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'ha965_5064));
        clk = 1'b0;
        reset_n = 1'b0;
        csr_req = '0;
        trap_req = '0;
        pc_if = '0;
        pc_wb = '0;
        hartid = $urandom;
        extern_intr = 1'b0;
        timer_intr = 1'b0;
        software_intr = 1'b0;
        csr_addrs = '{MVENDORID, MARCHID, MIMPID, MHARTID, MISA, MSTATUS, MIE, MTVEC,
                      MEPC, MCAUSE, MIP, 12'h340, 12'h343, PMPCFG_BASE + 12'd4};
        for (int k = 0; k < PMP_ENTRIES / 4; k++) csr_addrs.push_back(PMPCFG_BASE + 12'(k));
        for (int k = 0; k < PMP_ENTRIES; k++) csr_addrs.push_back(PMPADDR_BASE + 12'(k));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // identity and reset values, read only
        foreach (csr_addrs[i]) begin
            @(negedge clk);
            csr_req = '{en: 1'b1, op: CSR_OP_NONE, addr: csr_addrs[i], wdata: '0};
            #1 compare_outputs();
        end

        repeat (NUM_RANDOM) begin
            @(negedge clk);
            drive_random_cycle();
            #1 compare_outputs();
        end

        @(negedge clk);
        csr_req = '0;
        trap_req = '0;
        #1 compare_outputs();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb/csr_ref_model.sv
//////////////////////////////
// reference model of the machine CSR file for the testbench
// predicts read data, illegal flag and register outputs
//////////////////////////////
module csr_ref_model import csr_pkg::*; #(
    parameter int unsigned PMP_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  csr_req_t                         csr_req,
    input  trap_req_t                        trap_req,
    input  logic [XLEN-1:0]                  pc_if,
    input  logic [XLEN-1:0]                  pc_wb,
    input  logic [XLEN-1:0]                  hartid,
    input  logic                             extern_intr,
    input  logic                             timer_intr,
    input  logic                             software_intr,
    output logic [XLEN-1:0]                  exp_rdata,
    output logic                             exp_illegal,
    output logic [1:0]                       exp_priv,
    output logic                             exp_mstatus_mie,
    output logic [XLEN-1:0]                  exp_mie,
    output logic [XLEN-1:0]                  exp_mtvec,
    output logic [XLEN-1:0]                  exp_mepc,
    output logic [PMP_ENTRIES-1:0][7:0]      exp_pmpcfg,
    output logic [PMP_ENTRIES-1:0][XLEN-1:0] exp_pmpaddr
);

    logic [1:0]                       priv;
    logic [XLEN-1:0]                  mstatus;
    logic [XLEN-1:0]                  mie_reg;
    logic [XLEN-1:0]                  mip;
    logic [XLEN-1:0]                  mtvec;
    logic [XLEN-1:0]                  mepc;
    logic [XLEN-1:0]                  mcause;
    logic [PMP_ENTRIES-1:0][7:0]      cfg;
    logic [PMP_ENTRIES-1:0][XLEN-1:0] paddr;
    logic                             known;
    logic                             is_cfg;
    logic                             is_addr;
    logic                             legal;
    logic                             do_write;
    logic [XLEN-1:0]                  value;
    int                               slot;

    // only bits under mask take part in the operation
    function automatic logic [XLEN-1:0] masked_update(
        input csr_op_e         op,
        input logic [XLEN-1:0] old_val,
        input logic [XLEN-1:0] data,
        input logic [XLEN-1:0] mask
    );
        case (op)
            CSR_OP_WRITE: return (old_val & ~mask) | (data & mask);
            CSR_OP_SET:   return old_val | (data & mask);
            CSR_OP_CLEAR: return old_val & ~(data & mask);
            default:      return old_val;
        endcase
    endfunction

    //////////////////////////////
    // read side
    //////////////////////////////
    always_comb begin
        slot    = int'(csr_req.addr[3:0]);
        is_cfg  = csr_req.addr >= PMPCFG_BASE && csr_req.addr < PMPCFG_BASE + 12'(PMP_ENTRIES / 4);
        is_addr = csr_req.addr >= PMPADDR_BASE && csr_req.addr < PMPADDR_BASE + 12'(PMP_ENTRIES);
        known   = 1'b1;
        value   = '0;
        if (csr_req.addr == MHARTID) value = hartid;
        else if (csr_req.addr == MISA) value = ISA_CODE;
        else if (csr_req.addr == MSTATUS) value = mstatus;
        else if (csr_req.addr == MIE) value = mie_reg;
        else if (csr_req.addr == MIP) value = mip;
        else if (csr_req.addr == MTVEC) value = mtvec;
        else if (csr_req.addr == MEPC) value = mepc;
        else if (csr_req.addr == MCAUSE) value = mcause;
        else if (is_cfg) value = {cfg[4*slot+3], cfg[4*slot+2], cfg[4*slot+1], cfg[4*slot]};
        else if (is_addr) value = paddr[slot];
        else if (csr_req.addr != MVENDORID && csr_req.addr != MARCHID
                 && csr_req.addr != MIMPID) known = 1'b0;
        legal       = known && priv == 2'b11;
        exp_illegal = csr_req.en && !legal;
        exp_rdata   = (csr_req.en && legal) ? value : '0;
        do_write    = csr_req.en && legal && csr_req.op != CSR_OP_NONE;
    end

    //////////////////////////////
    // state update
    //////////////////////////////
    always @(posedge clk or negedge reset_n) begin : update
        logic [XLEN-1:0] next_status;
        logic [XLEN-1:0] byte_val;
        logic            frozen;
        if (!reset_n) begin
            priv    <= 2'b11;
            mstatus <= 32'h0000_0080;
            mie_reg <= '0;
            mip     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            cfg     <= '0;
            paddr   <= '0;
        end else begin
            next_status = mstatus;
            if (trap_req.take) begin
                next_status[3]     = 1'b0;
                next_status[7]     = mstatus[3];
                next_status[12:11] = priv;
                mepc   <= (trap_req.epc_sel == EPC_PC_WB ? pc_wb : pc_if) & ~32'h1;
                mcause <= {trap_req.irq, 26'b0, trap_req.code};
                priv   <= 2'b11;
            end else if (trap_req.mret) begin
                next_status[3]     = mstatus[7];
                next_status[7]     = 1'b1;
                next_status[12:11] = 2'b00;
                priv <= mstatus[12:11];
            end
            // CSR instruction beats the trap on the same register
            if (do_write) begin
                if (csr_req.addr == MSTATUS)
                    next_status = masked_update(csr_req.op, mstatus, csr_req.wdata, 32'h1888);
                if (csr_req.addr == MIE)
                    mie_reg <= masked_update(csr_req.op, mie_reg, csr_req.wdata, 32'h888);
                if (csr_req.addr == MTVEC)
                    mtvec <= masked_update(csr_req.op, mtvec, csr_req.wdata, 32'hFFFF_FF03);
                if (csr_req.addr == MEPC)
                    mepc <= masked_update(csr_req.op, mepc, csr_req.wdata, 32'hFFFF_FFFE);
                if (csr_req.addr == MCAUSE)
                    mcause <= masked_update(csr_req.op, mcause, csr_req.wdata, 32'h8000_001F);
                if (is_cfg) begin
                    for (int b = 0; b < 4; b++) begin
                        byte_val = masked_update(csr_req.op, XLEN'(cfg[4*slot+b]),
                                                 XLEN'(csr_req.wdata[8*b +: 8]), 32'hFF);
                        if (!cfg[4*slot+b][7]) cfg[4*slot+b] <= byte_val[7:0];
                    end
                end
                if (is_addr) begin
                    frozen = cfg[slot][7];
                    if (slot + 1 < PMP_ENTRIES) begin
                        frozen = frozen || (cfg[slot+1][7] && cfg[slot+1][4:3] == 2'b01);
                    end
                    if (!frozen)
                        paddr[slot] <= masked_update(csr_req.op, paddr[slot], csr_req.wdata, '1);
                end
            end
            mstatus <= next_status;
            mip     <= {20'b0, extern_intr, 3'b0, timer_intr, 3'b0, software_intr, 3'b0};
        end
    end

    assign exp_priv        = priv;
    assign exp_mstatus_mie = mstatus[3];
    assign exp_mie         = mie_reg;
    assign exp_mtvec       = mtvec;
    assign exp_mepc        = mepc;
    assign exp_pmpcfg      = cfg;
    assign exp_pmpaddr     = paddr;

endmodule
